// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f decode_stage.f --top-module tb_decode_stage -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -qx '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log

// File: control_decoder.sv
`timescale 1ns/1ps

module control_decoder (
	input  mips_pkg::opcode_e opcode,
	input  mips_pkg::funct_e  funct,
	output mips_pkg::ctrl_t   ctrl,
	output logic              take_jump,
	output logic              illegal
);
	import mips_pkg::*;

	always_comb begin
		// Bubble unless an opcode below claims it
		ctrl      = '0;
		take_jump = 1'b0;
		illegal   = 1'b0;
		case (opcode)
			R_TYPE: begin
				// Register ops write rd
				ctrl.reg_write  = 1'b1;
				ctrl.reg_dst_rd = 1'b1;
				case (funct)
					ADD: ctrl.alu_op = ALU_ADD;
					SUB: ctrl.alu_op = ALU_SUB;
					AND: ctrl.alu_op = ALU_AND;
					OR:  ctrl.alu_op = ALU_OR;
					SLT: ctrl.alu_op = ALU_SLT;
					JR: begin
						// Register jump with nothing written back
						ctrl      = '0;
						take_jump = 1'b1;
					end
					default: begin
						ctrl    = '0;
						illegal = 1'b1;
					end
				endcase
			end
			// Direct jumps with the link write handled past this stage
			J, JAL: take_jump = 1'b1;
			BEQ: begin
				ctrl.branch_eq = 1'b1;
				ctrl.alu_op    = ALU_SUB;
			end
			BNE: begin
				ctrl.branch_ne = 1'b1;
				ctrl.alu_op    = ALU_SUB;
			end
			// Immediates write rt
			ADDI, ANDI, ORI: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op      = (opcode == ANDI) ? ALU_AND :
					(opcode == ORI) ? ALU_OR : ALU_ADD;
			end
			LW: begin
				ctrl.reg_write   = 1'b1;
				ctrl.mem_read    = 1'b1;
				ctrl.mem_to_reg  = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			// Address add only
			SW: begin
				ctrl.mem_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			default: illegal = 1'b1;
		endcase
	end

	// Load and store are exclusive across every opcode
	always_comb begin
		a_mem_excl: assert (!(ctrl.mem_read && ctrl.mem_write));
	end

endmodule

// File: decode_stage.f
+incdir+.
mips_pkg.sv
register_file.sv
control_decoder.sv
instruction_decode.sv
id_ex_latch.sv
decode_stage.sv
tb_decode_stage.sv

// File: decode_stage.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module decode_stage (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic [`MIPS_DATA_W-1:0] instruction,
	input  logic [`MIPS_PC_W-1:0]   current_pc,
	input  logic [`MIPS_DATA_W-1:0] write_back_data,
	input  logic [`MIPS_REG_AW-1:0] write_back_address,
	input  logic                    reg_write,
	input  logic                    flush,
	output mips_pkg::id_ex_t        id_ex,
	output logic [`MIPS_PC_W-1:0]   jump_dest_addr,
	output logic                    take_jump
);
	import mips_pkg::*;

	// Decode result ahead of the latch
	id_ex_t id_next;

	// Fields, operands and control with jump outputs straight to fetch
	instruction_decode u_decode (
		.clock              (clock),
		.rst_n              (rst_n),
		.instruction        (instruction),
		.current_pc         (current_pc),
		.write_back_data    (write_back_data),
		.write_back_address (write_back_address),
		.reg_write          (reg_write),
		.id_next            (id_next),
		.jump_dest_addr     (jump_dest_addr),
		.take_jump          (take_jump)
	);

	// One cycle to execute
	id_ex_latch u_latch (
		.clock   (clock),
		.rst_n   (rst_n),
		.flush   (flush),
		.id_next (id_next),
		.id_ex   (id_ex)
	);

endmodule

// File: id_ex_latch.sv
`timescale 1ns/1ps

module id_ex_latch (
	input  logic             clock,
	input  logic             rst_n,
	input  logic             flush,
	input  mips_pkg::id_ex_t id_next,
	output mips_pkg::id_ex_t id_ex
);

	//////////////////////////////////////////////////////////////////////
	// ID/EX pipeline register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			// Bubble with every control bit inactive
			id_ex <= '0;
		end else begin
			id_ex <= id_next;
		end
	end

	// Flushed slot reaches execute as a bubble
	a_flush_bubble: assert property (@(posedge clock) disable iff (!rst_n)
		flush |=> (id_ex.ctrl == '0));

endmodule

// File: instruction_decode.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module instruction_decode (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic [`MIPS_DATA_W-1:0] instruction,
	input  logic [`MIPS_PC_W-1:0]   current_pc,
	input  logic [`MIPS_DATA_W-1:0] write_back_data,
	input  logic [`MIPS_REG_AW-1:0] write_back_address,
	input  logic                    reg_write,
	output mips_pkg::id_ex_t        id_next,
	output logic [`MIPS_PC_W-1:0]   jump_dest_addr,
	output logic                    take_jump
);
	import mips_pkg::*;

	// Instruction fields
	opcode_e                 opcode;
	funct_e                  funct;
	logic [`MIPS_REG_AW-1:0] rs;
	logic [`MIPS_REG_AW-1:0] rt;
	logic [`MIPS_REG_AW-1:0] rd;
	logic [15:0]             imm;

	// Derived values
	logic [`MIPS_DATA_W-1:0] sign_extended;
	logic [`MIPS_DATA_W-1:0] data_a;
	logic [`MIPS_DATA_W-1:0] data_b;
	logic [`MIPS_PC_W-1:0]   pc_plus_one;
	logic [`MIPS_PC_W-1:0]   branch_target;
	ctrl_t                   ctrl;
	logic                    illegal;

	//////////////////////////////////////////////////////////////////////
	// Field split
	//////////////////////////////////////////////////////////////////////

	assign opcode = opcode_e'(instruction[31:26]);
	assign rs     = instruction[25:21];
	assign rt     = instruction[20:16];
	assign rd     = instruction[15:11];
	assign imm    = instruction[15:0];
	assign funct  = funct_e'(instruction[5:0]);

	// Replicate bit 15 up to word width
	assign sign_extended = {{(`MIPS_DATA_W-16){imm[15]}}, imm};

	// Branch target wraps at PC width
	assign pc_plus_one   = current_pc + `MIPS_PC_W'(1);
	assign branch_target = pc_plus_one + sign_extended[`MIPS_PC_W-1:0];

	register_file u_regfile (
		.clock        (clock),
		.rst_n        (rst_n),
		.read_addr_a  (rs),
		.read_addr_b  (rt),
		.write_addr   (write_back_address),
		.write_data   (write_back_data),
		.write_enable (reg_write),
		.read_data_a  (data_a),
		.read_data_b  (data_b)
	);

	control_decoder u_ctrl (
		.opcode    (opcode),
		.funct     (funct),
		.ctrl      (ctrl),
		.take_jump (take_jump),
		.illegal   (illegal)
	);

	//////////////////////////////////////////////////////////////////////
	// Jump destination back to fetch
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (opcode == J || opcode == JAL) begin
			jump_dest_addr = instruction[`MIPS_PC_W-1:0];
		end else if (take_jump) begin
			// Only JR is left and takes its target from rs
			jump_dest_addr = data_a[`MIPS_PC_W-1:0];
		end else begin
			jump_dest_addr = branch_target;
		end
	end

	// Payload for the ID/EX latch
	always_comb begin
		id_next.ctrl            = ctrl;
		id_next.data_a          = data_a;
		id_next.data_b          = data_b;
		id_next.sign_extended   = sign_extended;
		id_next.reg_dest_r_type = rd;
		id_next.reg_dest_l_type = rt;
		id_next.pc_plus_one     = pc_plus_one;
	end

	// Fetch never redirected on a bad opcode
	a_no_illegal_jump: assert property (@(posedge clock) disable iff (!rst_n)
		!(illegal && take_jump));

endmodule

// File: mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath sizing fixed by the instruction format
//////////////////////////////////////////////////////////////////////

// Register and ALU word width
`define MIPS_DATA_W 32

// Register specifier width of the rs, rt and rd fields
`define MIPS_REG_AW 5

// Word-addressed program counter
`define MIPS_PC_W 11

// Architectural register count
`define MIPS_NUM_REGS 32

`endif

// File: mips_pkg.sv
`include "mips_params.svh"

package mips_pkg;

	//////////////////////////////////////////////////////////////////////
	// Instruction encodings
	//////////////////////////////////////////////////////////////////////

	// Primary opcode in bits 31:26
	typedef enum logic [5:0] {
		R_TYPE = 6'h00,
		J      = 6'h02,
		JAL    = 6'h03,
		BEQ    = 6'h04,
		BNE    = 6'h05,
		ADDI   = 6'h08,
		ANDI   = 6'h0c,
		ORI    = 6'h0d,
		LW     = 6'h23,
		SW     = 6'h2b
	} opcode_e;

	// Function field for R-type in bits 5:0
	typedef enum logic [5:0] {
		JR  = 6'h08,
		ADD = 6'h20,
		SUB = 6'h22,
		AND = 6'h24,
		OR  = 6'h25,
		SLT = 6'h2a
	} funct_e;

	// Operation handed to the execute stage
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4
	} alu_op_e;

	//////////////////////////////////////////////////////////////////////
	// Pipeline payloads
	//////////////////////////////////////////////////////////////////////

	// Control bits where all zero is a bubble
	typedef struct packed {
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    mem_to_reg;
		logic    alu_src_imm;
		logic    reg_dst_rd;
		logic    branch_eq;
		logic    branch_ne;
		alu_op_e alu_op;
	} ctrl_t;

	// Contents of the ID/EX latch
	typedef struct packed {
		ctrl_t                   ctrl;
		logic [`MIPS_DATA_W-1:0] data_a;
		logic [`MIPS_DATA_W-1:0] data_b;
		logic [`MIPS_DATA_W-1:0] sign_extended;
		logic [`MIPS_REG_AW-1:0] reg_dest_r_type;
		logic [`MIPS_REG_AW-1:0] reg_dest_l_type;
		logic [`MIPS_PC_W-1:0]   pc_plus_one;
	} id_ex_t;

endpackage

// File: register_file.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module register_file (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic [`MIPS_REG_AW-1:0] read_addr_a,
	input  logic [`MIPS_REG_AW-1:0] read_addr_b,
	input  logic [`MIPS_REG_AW-1:0] write_addr,
	input  logic [`MIPS_DATA_W-1:0] write_data,
	input  logic                    write_enable,
	output logic [`MIPS_DATA_W-1:0] read_data_a,
	output logic [`MIPS_DATA_W-1:0] read_data_b
);

	// Register array
	logic [`MIPS_DATA_W-1:0] regs [`MIPS_NUM_REGS];

	// Write to r0 is dropped
	logic write_valid;

	assign write_valid = write_enable && (write_addr != '0);

	//////////////////////////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			// Clear every entry
			for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (write_valid) begin
			regs[write_addr] <= write_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read ports with write-through
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// Port A
		if (read_addr_a == '0) begin
			read_data_a = '0;
		end else if (write_valid && (write_addr == read_addr_a)) begin
			read_data_a = write_data;
		end else begin
			read_data_a = regs[read_addr_a];
		end
		// Port B by the same rule
		if (read_addr_b == '0) begin
			read_data_b = '0;
		end else if (write_valid && (write_addr == read_addr_b)) begin
			read_data_b = write_data;
		end else begin
			read_data_b = regs[read_addr_b];
		end
	end

	// r0 stays zero once reset has run
	a_r0_zero: assert property (@(posedge clock) disable iff (!rst_n) regs[0] == '0);

endmodule

// File: tb_decode_stage.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module tb_decode_stage;
	import mips_pkg::*;

	// Test lengths in cycles
	localparam int RESET_CYCLES = 16;
	localparam int REG_READS    = 16;
	localparam int REG_PAIRS    = 200;
	localparam int FIELD_COUNT  = 300;
	localparam int JUMP_COUNT   = 200;
	localparam int FLUSH_COUNT  = 200;
	localparam int CYCLE_LIMIT  = RESET_CYCLES + REG_READS + 2 * REG_PAIRS + FIELD_COUNT +
		JUMP_COUNT + FLUSH_COUNT + 100;

	logic                    clock;
	logic                    rst_n;
	logic [`MIPS_DATA_W-1:0] instruction;
	logic [`MIPS_PC_W-1:0]   current_pc;
	logic [`MIPS_DATA_W-1:0] write_back_data;
	logic [`MIPS_REG_AW-1:0] write_back_address;
	logic                    reg_write;
	logic                    flush;
	id_ex_t                  id_ex;
	logic [`MIPS_PC_W-1:0]   jump_dest_addr;
	logic                    take_jump;

	// Shadow register file
	logic [`MIPS_DATA_W-1:0] model_regs [`MIPS_NUM_REGS];
	logic [31:0]             rng_state;
	string                   test_name;
	int                      checks = 0;
	int                      errors = 0;
	int                      test_checks = 0;
	int                      test_errors = 0;
	int                      cycles = 0;

	decode_stage uut (
		.clock              (clock),
		.rst_n              (rst_n),
		.instruction        (instruction),
		.current_pc         (current_pc),
		.write_back_data    (write_back_data),
		.write_back_address (write_back_address),
		.reg_write          (reg_write),
		.flush              (flush),
		.id_ex              (id_ex),
		.jump_dest_addr     (jump_dest_addr),
		.take_jump          (take_jump)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Run limit
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout, run stopped after %0d cycles", cycles);
			$display("** FAIL **");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Random source and reference model
	//////////////////////////////////////////////////////////////////////

	// 32-bit xorshift
	function automatic logic [31:0] next_random();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic logic [5:0] legal_opcode(input logic [31:0] sel);
		case (sel % 10)
			0: return 6'h00;
			1: return 6'h02;
			2: return 6'h03;
			3: return 6'h04;
			4: return 6'h05;
			5: return 6'h08;
			6: return 6'h0c;
			7: return 6'h0d;
			8: return 6'h23;
			default: return 6'h2b;
		endcase
	endfunction

	function automatic logic [5:0] legal_funct(input logic [31:0] sel);
		case (sel % 6)
			0: return 6'h20;
			1: return 6'h22;
			2: return 6'h24;
			3: return 6'h25;
			4: return 6'h2a;
			default: return 6'h08;
		endcase
	endfunction

	function automatic logic [31:0] rtype_instr(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, 5'd0, fn};
	endfunction

	// Control per MIPS encoding
	// Bit order rw, mem_rd, mem_wr, mem_to_reg, imm, rd, beq, bne, then alu_op
	function automatic ctrl_t decode_table(input logic [5:0] op, input logic [5:0] fn);
		case (op)
			6'h00: begin
				case (fn)
					6'h20: return ctrl_t'({8'b1000_0100, ALU_ADD});
					6'h22: return ctrl_t'({8'b1000_0100, ALU_SUB});
					6'h24: return ctrl_t'({8'b1000_0100, ALU_AND});
					6'h25: return ctrl_t'({8'b1000_0100, ALU_OR});
					6'h2a: return ctrl_t'({8'b1000_0100, ALU_SLT});
					// JR and unknown functions
					default: return '0;
				endcase
			end
			6'h04: return ctrl_t'({8'b0000_0010, ALU_SUB});
			6'h05: return ctrl_t'({8'b0000_0001, ALU_SUB});
			6'h08: return ctrl_t'({8'b1000_1000, ALU_ADD});
			6'h0c: return ctrl_t'({8'b1000_1000, ALU_AND});
			6'h0d: return ctrl_t'({8'b1000_1000, ALU_OR});
			6'h23: return ctrl_t'({8'b1101_1000, ALU_ADD});
			6'h2b: return ctrl_t'({8'b0010_1000, ALU_ADD});
			// J, JAL and unknown opcodes
			default: return '0;
		endcase
	endfunction

	// Read with r0 and same-cycle bypass
	function automatic logic [31:0] model_read(input logic [4:0] addr, input logic wb_en,
		input logic [4:0] wb_addr, input logic [31:0] wb_data);
		if (addr == 5'd0) return '0;
		if (wb_en && wb_addr == addr) return wb_data;
		return model_regs[addr];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checks and drive
	//////////////////////////////////////////////////////////////////////

	task automatic check_value(input string what, input logic [127:0] expected,
		input logic [127:0] actual);
		checks++;
		test_checks++;
		if (expected !== actual) begin
			errors++;
			test_errors++;
			$display("ERR %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic end_test();
		$display("%s done, %0d checks, %0d errors", test_name, test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	// One instruction from a falling edge to the next
	task automatic drive_cycle(input logic [31:0] instr, input logic [10:0] pc,
		input logic wb_en, input logic [4:0] wb_addr, input logic [31:0] wb_data,
		input logic fl);
		id_ex_t      expected;
		logic [31:0] a;
		logic [10:0] dest;
		logic        is_j;
		logic        is_jr;
		instruction        = instr;
		current_pc         = pc;
		reg_write          = wb_en;
		write_back_address = wb_addr;
		write_back_data    = wb_data;
		flush              = fl;
		a = model_read(instr[25:21], wb_en, wb_addr, wb_data);
		expected.ctrl            = decode_table(instr[31:26], instr[5:0]);
		expected.data_a          = a;
		expected.data_b          = model_read(instr[20:16], wb_en, wb_addr, wb_data);
		expected.sign_extended   = {{16{instr[15]}}, instr[15:0]};
		expected.reg_dest_r_type = instr[15:11];
		expected.reg_dest_l_type = instr[20:16];
		expected.pc_plus_one     = pc + 11'd1;
		is_j  = instr[31:26] == 6'h02 || instr[31:26] == 6'h03;
		is_jr = instr[31:26] == 6'h00 && instr[5:0] == 6'h08;
		// Offset cut to PC width is just the low immediate bits
		dest = is_j ? instr[10:0] : is_jr ? a[10:0] : pc + 11'd1 + instr[10:0];
		if (fl) expected = '0;
		// Jump outputs settle within the same cycle
		#1;
		check_value("take_jump", 128'(is_j || is_jr), 128'(take_jump));
		check_value("jump_dest_addr", 128'(dest), 128'(jump_dest_addr));
		@(posedge clock);
		if (wb_en && wb_addr != 5'd0) model_regs[wb_addr] = wb_data;
		@(negedge clock);
		check_value("id_ex", expected, id_ex);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		logic [31:0] instr;
		logic [4:0]  wa;
		logic [5:0]  op;
		rng_state          = 32'd8;
		rst_n              = 1'b0;
		instruction        = '0;
		current_pc         = '0;
		write_back_data    = '0;
		write_back_address = '0;
		reg_write          = 1'b0;
		flush              = 1'b0;
		for (int i = 0; i < `MIPS_NUM_REGS; i++) model_regs[i] = '0;

		// Writes and instructions offered during reset must not land
		test_name = "reset";
		for (int i = 0; i < RESET_CYCLES; i++) begin
			instruction        = next_random();
			reg_write          = 1'b1;
			write_back_address = 5'(2 * i + 1);
			write_back_data    = next_random();
			@(negedge clock);
		end
		reg_write = 1'b0;
		// Latch and registers cleared
		check_value("id_ex", '0, id_ex);
		rst_n = 1'b1;
		for (int i = 0; i < REG_READS; i++) begin
			drive_cycle(rtype_instr(5'(2 * i), 5'(2 * i + 1), 5'd0, 6'h20), '0, 1'b0, '0, '0,
				1'b0);
		end
		end_test();

		// Each write is read in the same cycle and then a random pair follows
		// Every 8th write aims at r0
		test_name = "regfile";
		for (int i = 0; i < REG_PAIRS; i++) begin
			r  = next_random();
			wa = (i % 8 == 0) ? 5'd0 : r[4:0];
			drive_cycle(rtype_instr(wa, r[9:5], r[14:10], 6'h20), r[25:15], 1'b1, wa,
				next_random(), 1'b0);
			r = next_random();
			drive_cycle(rtype_instr((i % 8 == 0) ? 5'd0 : r[4:0], r[9:5], r[14:10], 6'h20),
				r[25:15], 1'b0, '0, '0, 1'b0);
		end
		end_test();

		// Legal opcodes, random fields
		test_name = "decode";
		for (int i = 0; i < FIELD_COUNT; i++) begin
			instr = next_random();
			r     = next_random();
			instr[31:26] = legal_opcode(r);
			if (instr[31:26] == 6'h00) instr[5:0] = legal_funct(r >> 4);
			drive_cycle(instr, r[26:16], r[0], r[5:1], next_random(), 1'b0);
		end
		end_test();

		// Branches and jumps
		test_name = "jump";
		for (int i = 0; i < JUMP_COUNT; i++) begin
			instr = next_random();
			r     = next_random();
			case (r % 5)
				0: instr[31:26] = 6'h04;
				1: instr[31:26] = 6'h05;
				2: instr[31:26] = 6'h02;
				3: instr[31:26] = 6'h03;
				default: begin
					instr[31:26] = 6'h00;
					instr[5:0]   = 6'h08;
				end
			endcase
			drive_cycle(instr, r[26:16], r[3], r[8:4], next_random(), 1'b0);
		end
		end_test();

		// Random flush with unknown opcodes on a quarter of cycles
		test_name = "flush";
		for (int i = 0; i < FLUSH_COUNT; i++) begin
			instr = next_random();
			r     = next_random();
			op    = instr[31:26];
			if (r[1:0] == 2'd0) begin
				// Step off any known encoding
				while (op inside {6'h00, 6'h02, 6'h03, 6'h04, 6'h05, 6'h08, 6'h0c, 6'h0d,
					6'h23, 6'h2b}) op = op + 6'd1;
			end else begin
				op = legal_opcode(r >> 8);
			end
			instr[31:26] = op;
			drive_cycle(instr, r[26:16], r[2], r[7:3], next_random(), r[30:29] == 2'd0);
		end
		end_test();

		$display("Total %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule
